//--- logic/fetchPkg.sv
package fetchPkg;

    // ROM and cache line geometry
    localparam int romWords = 128;
    localparam int clWords = 4;
    localparam int lineBytes = clWords * 4;
    localparam int romIdxWidth = $clog2(romWords);
    localparam int clOffWidth = $clog2(clWords);

    // Request ids, four tags in flight at most
    localparam int memIdWidth = 2;
    localparam int numMemIds = 1 << memIdWidth;

    // Queue depth, one credit per buffered line
    localparam int queueLines = 4;
    localparam int creditWidth = $clog2(queueLines + 1);

    typedef logic [31:0] tWord;
    typedef logic [memIdWidth-1:0] tMemId;

    // Word 0 sits in the low 32 bits
    typedef tWord [clWords-1:0] tCacheLine;

    // Line request, addr is line aligned
    typedef struct packed {
        logic  valid;
        tMemId id;
        tWord  addr;
    } tMemReqPkt;

    // Line response, same id as its request
    typedef struct packed {
        logic      valid;
        tMemId     id;
        tCacheLine data;
    } tMemRspPkt;

    // One instruction toward decode
    typedef struct packed {
        logic valid;
        tWord pc;
        tWord instr;
    } tFetchInstr;

    // RISC-V major opcodes
    typedef enum logic [6:0] {
        opImm  = 7'b0010011,
        op     = 7'b0110011,
        branch = 7'b1100011,
        load   = 7'b0000011,
        system = 7'b1110011
    } tRvOpcode;

    // Fill buffer is idle until the first redirect
    typedef enum logic {
        fbIdle,
        fbStream
    } tFbState;

    // I-type ADDI, funct3 000
    function automatic tWord rvAddi(input logic [4:0] rd, input logic [4:0] rs1,
                                    input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, opImm};
    endfunction

    // EBREAK, imm 1 under SYSTEM
    function automatic tWord rvEbreak();
        return {12'h001, 5'd0, 3'b000, 5'd0, system};
    endfunction

endpackage

//--- logic/instrRom.sv
`timescale 1ns/1ps

module instrRom #(
    parameter int LATENCY = 2
) (
    input  logic                clk,
    input  logic                arstN,
    input  fetchPkg::tMemReqPkt memReq,
    output fetchPkg::tMemRspPkt memRsp
);
    import fetchPkg::*;

    tWord romMem [romWords];

    // Response pipeline, stage 0 is the lookup register
    logic      pipeValid [LATENCY];
    tMemId     pipeId [LATENCY];
    tCacheLine pipeData [LATENCY];

    tCacheLine readLine;

    // Fixed program: ADDI x(i%32), x0, i and EBREAK at the end
    initial begin
        for (int i = 0; i < romWords; i++) begin
            romMem[i] = rvAddi(5'(i % 32), 5'd0, 12'(i));
        end
        romMem[romWords-1] = rvEbreak();
    end

    // Word index from byte address, wraps at the ROM end
    always_comb begin
        logic [romIdxWidth-1:0] idx;
        idx = memReq.addr[2 +: romIdxWidth];
        for (int w = 0; w < clWords; w++) begin
            readLine[w] = romMem[idx];
            idx = idx + 1'b1;
        end
    end

    // Valid bits only
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int s = 0; s < LATENCY; s++) begin
                pipeValid[s] <= 1'b0;
            end
        end else begin
            pipeValid[0] <= memReq.valid;
            for (int s = 1; s < LATENCY; s++) begin
                pipeValid[s] <= pipeValid[s-1];
            end
        end
    end

    // Id and data ride along with valid
    always_ff @(posedge clk) begin
        pipeId[0] <= memReq.id;
        pipeData[0] <= readLine;
        for (int s = 1; s < LATENCY; s++) begin
            pipeId[s] <= pipeId[s-1];
            pipeData[s] <= pipeData[s-1];
        end
    end

    assign memRsp = '{valid: pipeValid[LATENCY-1], id: pipeId[LATENCY-1],
                      data: pipeData[LATENCY-1]};

endmodule

//--- logic/fetchFillBuffer.sv
`timescale 1ns/1ps

module fetchFillBuffer (
    input  logic                clk,
    input  logic                arstN,
    input  logic                redirect,
    input  fetchPkg::tWord      redirectPc,
    input  logic                lineFreed,
    output fetchPkg::tMemReqPkt memReq,
    input  fetchPkg::tMemRspPkt memRsp,
    output fetchPkg::tMemRspPkt lineOut,
    output fetchPkg::tWord      lineAddr
);
    import fetchPkg::*;

    tFbState fbState;
    tWord nextAddr;
    tMemId nextId;
    logic [creditWidth-1:0] credits;

    // Per-id bookkeeping
    tWord idAddr [numMemIds];
    logic [numMemIds-1:0] idStale;
    logic [numMemIds-1:0] inFlight;

    logic rspStale;
    logic issue;
    logic [numMemIds-1:0] stillFlying;
    logic [creditWidth-1:0] freeCredits;
    tWord issueAddr;

    always_comb begin
        // Anything returning in a redirect cycle is from the old stream
        rspStale = memRsp.valid && (idStale[memRsp.id] || redirect);
        stillFlying = inFlight;
        if (memRsp.valid) begin
            stillFlying[memRsp.id] = 1'b0;
        end
        if (redirect) begin
            // Queue is flushed, old lines still out hold their credit until they return
            freeCredits = creditWidth'(queueLines) - creditWidth'($countones(stillFlying));
            issueAddr = redirectPc & ~tWord'(lineBytes - 1);
        end else begin
            freeCredits = credits;
            issueAddr = nextAddr;
        end
        issue = (redirect || fbState == fbStream) && freeCredits != '0;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fbState <= fbIdle;
            nextAddr <= '0;
            nextId <= '0;
            credits <= '0;
            idStale <= '0;
            inFlight <= '0;
            memReq <= '0;
        end else begin
            memReq.valid <= issue;
            inFlight <= stillFlying;
            if (redirect) begin
                fbState <= fbStream;
                nextAddr <= issueAddr;
                idStale <= '1;
                credits <= freeCredits - creditWidth'(issue);
            end else begin
                credits <= credits - creditWidth'(issue) + creditWidth'(lineFreed)
                         + creditWidth'(rspStale);
            end
            // New request overrides the stale mark of a reused id
            if (issue) begin
                memReq.id <= nextId;
                memReq.addr <= issueAddr;
                nextId <= nextId + 1'b1;
                nextAddr <= issueAddr + tWord'(lineBytes);
                inFlight[nextId] <= 1'b1;
                idStale[nextId] <= 1'b0;
            end
        end
    end

    // Line address per id, read back on response
    always_ff @(posedge clk) begin
        if (issue) begin
            idAddr[nextId] <= issueAddr;
        end
    end

    // Same-cycle forward to the queue
    always_comb begin
        lineOut = memRsp;
        lineOut.valid = memRsp.valid && !rspStale;
    end

    assign lineAddr = idAddr[memRsp.id];

endmodule

//--- logic/fetchInstrQueue.sv
`timescale 1ns/1ps

module fetchInstrQueue (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 redirect,
    input  fetchPkg::tWord       redirectPc,
    input  logic                 stall,
    input  fetchPkg::tMemRspPkt  lineIn,
    input  fetchPkg::tWord       lineAddr,
    output logic                 lineFreed,
    output fetchPkg::tFetchInstr fetchOut
);
    import fetchPkg::*;

    localparam int ptrWidth = $clog2(queueLines);

    // Circular line buffer
    tCacheLine lineMem [queueLines];
    tWord addrMem [queueLines];

    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth:0] count;
    logic [clOffWidth-1:0] wordPtr;

    logic push;
    logic avail;
    logic advance;
    logic lastWord;

    // Lines landing in the redirect cycle belong to the old stream
    assign push = lineIn.valid && !redirect;
    assign avail = count != '0;
    assign advance = avail && !stall && !redirect;
    assign lastWord = wordPtr == clOffWidth'(clWords - 1);

    // Head line done
    assign lineFreed = advance && lastWord;

    always_ff @(posedge clk) begin
        if (push) begin
            lineMem[wrPtr] <= lineIn.data;
            addrMem[wrPtr] <= lineAddr;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            wordPtr <= '0;
            fetchOut <= '0;
        end else if (redirect) begin
            // Flush, first line starts at the target word
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            wordPtr <= redirectPc[2 +: clOffWidth];
            fetchOut.valid <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            count <= count + (ptrWidth + 1)'(push) - (ptrWidth + 1)'(lineFreed);
            // Stall holds the output register
            if (!stall) begin
                fetchOut.valid <= avail;
                if (avail) begin
                    fetchOut.pc <= addrMem[rdPtr] + tWord'({wordPtr, 2'b00});
                    fetchOut.instr <= lineMem[rdPtr][wordPtr];
                end
            end
            if (advance) begin
                if (lastWord) begin
                    rdPtr <= rdPtr + 1'b1;
                    wordPtr <= '0;
                end else begin
                    wordPtr <= wordPtr + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/fetchTop.sv
`timescale 1ns/1ps

module fetchTop (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 redirect,
    input  fetchPkg::tWord       redirectPc,
    input  logic                 stall,
    output fetchPkg::tFetchInstr fetchOut
);
    import fetchPkg::*;

    tMemReqPkt memReq;
    tMemRspPkt memRsp;
    tMemRspPkt lineOut;
    tWord lineAddr;
    logic lineFreed;

    // Line requests, stale filtering and credits
    fetchFillBuffer fetchFillBuffer_inst (
        .clk        (clk),
        .arstN      (arstN),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .lineFreed  (lineFreed),
        .memReq     (memReq),
        .memRsp     (memRsp),
        .lineOut    (lineOut),
        .lineAddr   (lineAddr)
    );

    // Stand-in for the instruction cache
    instrRom #(
        .LATENCY (2)
    ) instrRom_inst (
        .clk    (clk),
        .arstN  (arstN),
        .memReq (memReq),
        .memRsp (memRsp)
    );

    // Line to instruction split toward decode
    fetchInstrQueue fetchInstrQueue_inst (
        .clk        (clk),
        .arstN      (arstN),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .stall      (stall),
        .lineIn     (lineOut),
        .lineAddr   (lineAddr),
        .lineFreed  (lineFreed),
        .fetchOut   (fetchOut)
    );

endmodule

//--- verification/fetchTb.sv
`timescale 1ns/1ps

module fetchTb;
    import fetchPkg::*;

    logic clk;
    logic arstN;
    logic redirect;
    tWord redirectPc;
    logic stall;
    tFetchInstr fetchOut;

    // Reference model state
    tWord expPc;
    logic seenRedirect;
    // Previous cycle was stalled and had no redirect
    logic holdCheck;
    tFetchInstr heldOut;
    int acceptCount;
    logic randomStall;

    fetchTop fetchTop_inst (
        .clk        (clk),
        .arstN      (arstN),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .stall      (stall),
        .fetchOut   (fetchOut)
    );

    always #5 clk = ~clk;

    // ROM program as seen from a PC with the index wrapping at the ROM end
    function automatic tWord romRule(input tWord pc);
        logic [romIdxWidth-1:0] idx;
        idx = pc[2 +: romIdxWidth];
        if (idx == romIdxWidth'(romWords - 1)) begin
            return rvEbreak();
        end
        return rvAddi(idx[4:0], 5'd0, 12'(idx));
    endfunction

    task automatic reportMismatch(input string what);
        $display("** Error at %0d ns: %s", $time, what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // An output counts as taken on an unstalled cycle
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            expPc <= '0;
            seenRedirect <= 1'b0;
            holdCheck <= 1'b0;
            heldOut <= '0;
            acceptCount <= 0;
        end else begin
            holdCheck <= stall && !redirect;
            heldOut <= fetchOut;
            if (fetchOut.valid && !stall) begin
                acceptCount <= acceptCount + 1;
            end
            // New stream restarts the expected PC
            if (redirect) begin
                seenRedirect <= 1'b1;
                expPc <= redirectPc;
            end else if (fetchOut.valid && !stall) begin
                expPc <= expPc + 32'd4;
            end
        end
    end

    // Quiet until the first redirect
    idleCheck: assert property (@(posedge clk) disable iff (!arstN)
        seenRedirect || !fetchOut.valid)
        else reportMismatch("fetchOut valid before any redirect");

    // PC sequence with no gap or repeat and nothing from an old stream
    pcCheck: assert property (@(posedge clk) disable iff (!arstN)
        !(fetchOut.valid && !stall) || fetchOut.pc == expPc)
        else reportMismatch($sformatf("pc %h, expected %h",
                                      $sampled(fetchOut.pc), $sampled(expPc)));

    instrCheck: assert property (@(posedge clk) disable iff (!arstN)
        !(fetchOut.valid && !stall) || fetchOut.instr == romRule(expPc))
        else reportMismatch($sformatf("instr %h at pc %h, expected %h",
                                      $sampled(fetchOut.instr), $sampled(expPc),
                                      romRule($sampled(expPc))));

    // Stalled output must not move
    holdAssert: assert property (@(posedge clk) disable iff (!arstN)
        !holdCheck || fetchOut == heldOut)
        else reportMismatch("fetchOut changed during stall");

    // Wait for one taken instruction within 200 cycles
    task automatic awaitOutput();
        int start;
        int cycles;
        start = acceptCount;
        cycles = 0;
        while (acceptCount == start && cycles < 200) begin
            @(negedge clk);
            stall = randomStall & 1'($urandom);
            cycles++;
        end
        if (acceptCount == start) begin
            $display("Timeout: no instruction was handed to decode within 200 cycles");
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic streamOutputs(input int n);
        for (int i = 0; i < n; i++) begin
            awaitOutput();
        end
    endtask

    task automatic redirectTo(input tWord target);
        @(negedge clk);
        redirect = 1'b1;
        redirectPc = target;
        @(negedge clk);
        redirect = 1'b0;
    endtask

    // Two redirect cycles in a row
    task automatic redirectTwice(input tWord first, input tWord second);
        @(negedge clk);
        redirect = 1'b1;
        redirectPc = first;
        @(negedge clk);
        redirectPc = second;
        @(negedge clk);
        redirect = 1'b0;
    endtask

    initial begin
        int seedSink;
        clk = 1'b0;
        arstN = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        stall = 1'b0;
        randomStall = 1'b0;
        seedSink = $urandom(32'h1637798e);
        repeat (10) @(negedge clk);
        arstN = 1'b1;
        // Idle after reset with stall wiggling
        repeat (20) begin
            @(negedge clk);
            stall = 1'($urandom);
        end
        stall = 1'b0;
        // Aligned stream
        redirectTo(32'h40);
        streamOutputs(40);
        // Unaligned targets at offsets 1 to 3
        for (int off = 1; off < 4; off++) begin
            redirectTo(32'h100 + tWord'(off * 4));
            streamOutputs(6);
        end
        // Random stall
        randomStall = 1'b1;
        redirectTo(32'h20);
        streamOutputs(60);
        // Redirects with lines in flight while stall stays random
        redirectTo(32'h80);
        streamOutputs(3);
        redirectTo(32'h1c4);
        streamOutputs(8);
        redirectTo(32'h60);
        redirectTo(32'h10c);
        streamOutputs(5);
        redirectTwice(32'h30, 32'h148);
        streamOutputs(8);
        randomStall = 1'b0;
        redirectTwice(32'h90, 32'h18);
        streamOutputs(6);
        // Through EBREAK at word 127 and wrap to index 0
        redirectTo(32'd496);
        streamOutputs(12);
        stall = 1'b0;
        repeat (5) @(negedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

//--- filelist.f
logic/fetchPkg.sv
logic/instrRom.sv
logic/fetchFillBuffer.sv
logic/fetchInstrQueue.sv
logic/fetchTop.sv
verification/fetchTb.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench

SIM       = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing
TOP       = fetchTb
FILELIST  = filelist.f
BUILDDIR  = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILDDIR)

# Pass only when the log holds the pass line
run: build
	-./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed" && exit 1)

lint:
	$(SIM) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILDDIR) $(LOG)
